// File: list.f
src/oob_down_pkg.sv
src/cmd_fifo.sv
src/cmd_prefetch.sv
src/oob_pkt_fsm.sv
src/oob_down_top.sv
test/oob_down_checker.sv
test/tb_oob_down.sv

// File: Bender.yml
package:
  name: oob_down

sources:
  - src/oob_down_pkg.sv
  - src/cmd_fifo.sv
  - src/cmd_prefetch.sv
  - src/oob_pkt_fsm.sv
  - src/oob_down_top.sv
  - target: test
    files:
      - test/oob_down_checker.sv
      - test/tb_oob_down.sv

// File: test/tb_oob_down.sv
/*
 * Testbench for the OOB downstream controller
 * Reset, single command, random stream, downstream stall and error lock
 */
`timescale 1ns/1ns
`default_nettype none

module tb_oob_down
  import oob_down_pkg::*;
();

  localparam int RESET_CYCLES = 5;
  localparam int NUM_RANDOM   = 30;
  localparam int STALL_CYCLES = 40;
  localparam int WATCH_CYCLES = 20;
  // Stall phase takes at most a full queue plus the pipe
  localparam int MAX_CMDS     = 1 + NUM_RANDOM + FIFO_DEPTH + 2 + 3;
  localparam int CYCLE_LIMIT  = 40 * MAX_CMDS + STALL_CYCLES + WATCH_CYCLES;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic        clk;
  logic        rst_n;
  logic        cmd_valid;
  oob_cmd_t    cmd;
  logic        cmd_ready;
  logic        oob_ready;
  oob_beat_t   oob;
  logic        err;
  int          error_count;
  int          pending;
  int          beat_count;
  logic [31:0] lfsr;
  int          tb_errors;
  int          test_mark;
  int          beat_mark;
  int          cycles;
  int          i;
  logic        saw_ready_low;
  oob_cmd_t    bad_cmd;

  oob_down_top dut0 (.*);

  oob_down_checker u_checker (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // --------------------
  // Random fields

  // Galois step per bit, the bit shifted out is the one taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
        lfsr = lfsr ^ LFSR_TAPS;
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic oob_cmd_t random_cmd();
    oob_cmd_t    r;
    logic [31:0] v;
    r.cntl      = SOM_EOM;
    v           = take_bits(TAG_W);
    r.tag       = v[TAG_W-1:0];
    v           = take_bits(LANES_W);
    r.num_lanes = v[LANES_W-1:0];
    v           = take_bits(OPT_VAL_W);
    r.stop_cmd  = v[OPT_VAL_W-1:0];
    v           = take_bits(OPT_VAL_W);
    r.simd_cmd  = v[OPT_VAL_W-1:0];
    return r;
  endfunction

  // --------------------
  // Helpers

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: %s expected %h got %h", $time, name, exp, got);
      tb_errors++;
    end
  endtask

  task automatic check_idle();
    check_value("oob.valid", oob.valid, 1'b0);
    check_value("err", err, 1'b0);
    check_value("cmd_ready", cmd_ready, 1'b0);
  endtask

  // Next edge at which ready is seen high carries the command
  task automatic send_cmd(input oob_cmd_t c);
    @(posedge clk);
    while (!cmd_ready)
    begin
      cmd_valid <= 1'b0;
      @(posedge clk);
    end
    cmd_valid <= 1'b1;
    cmd       <= c;
  endtask

  task automatic end_burst();
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_drained();
    @(posedge clk);
    while (pending != 0)
      @(posedge clk);
  endtask

  task automatic finish_test(input string name);
    int n;
    n = tb_errors + error_count - test_mark;
    $display("Test %s finished with %0d errors", name, n);
    test_mark = tb_errors + error_count;
  endtask

  // --------------------
  // Test sequence

  initial
  begin
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    oob_ready = 1'b1;
    lfsr      = 32'he84c;
    tb_errors = 0;
    test_mark = 0;

    @(posedge clk);
    for (i = 1; i < RESET_CYCLES; i++)
    begin
      @(posedge clk);
      check_idle();
    end
    rst_n <= 1'b1;
    @(posedge clk);
    check_idle();
    @(posedge clk);
    check_value("cmd_ready", cmd_ready, 1'b1);
    finish_test("reset");

    beat_mark = beat_count;
    send_cmd(random_cmd());
    end_burst();
    wait_drained();
    check_value("beat count", beat_count - beat_mark, 2);
    finish_test("single command");

    beat_mark = beat_count;
    for (i = 0; i < NUM_RANDOM; i++)
      send_cmd(random_cmd());
    end_burst();
    wait_drained();
    check_value("beat count", beat_count - beat_mark, 2 * NUM_RANDOM);
    finish_test("random stream");

    // Downstream holds off, queue fills behind the generator
    oob_ready     <= 1'b0;
    saw_ready_low = 1'b0;
    beat_mark     = beat_count;
    repeat (2) @(posedge clk);
    for (i = 0; i < STALL_CYCLES; i++)
    begin
      @(posedge clk);
      if (cmd_ready)
      begin
        cmd_valid <= 1'b1;
        cmd       <= random_cmd();
      end
      else
      begin
        cmd_valid     <= 1'b0;
        saw_ready_low = 1'b1;
      end
    end
    end_burst();
    if (!saw_ready_low)
    begin
      $display("cmd_ready never fell while the downstream side was stalled");
      tb_errors++;
    end
    check_value("beat count in stall", beat_count - beat_mark, 0);
    oob_ready <= 1'b1;
    wait_drained();
    finish_test("downstream stall");

    bad_cmd      = random_cmd();
    bad_cmd.cntl = SOM;
    send_cmd(bad_cmd);
    send_cmd(random_cmd());
    send_cmd(random_cmd());
    end_burst();
    while (!err)
      @(posedge clk);
    beat_mark = beat_count;
    repeat (WATCH_CYCLES) @(posedge clk);
    check_value("beat count after err", beat_count - beat_mark, 0);
    check_value("err", err, 1'b1);
    @(posedge clk);
    finish_test("error lock");

    $display("Tests run: 5, errors: %0d", tb_errors + error_count);
    if (tb_errors + error_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // Run limit from the command budget
  initial
  begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the run did not complete", cycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/oob_down_checker.sv
/*
 * OOB downstream scoreboard
 * Predicts the two beats of every accepted command and compares them,
 * in order, with the beats that the DUT sends
 */
`timescale 1ns/1ns
`default_nettype none

module oob_down_checker
  import oob_down_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_valid,
  input  oob_cmd_t  cmd,
  input  oob_beat_t oob,
  input  logic      err,
  output int        error_count,
  output int        pending,
  output int        beat_count
);

  oob_beat_t exp_q[$];
  oob_beat_t exp_beat;
  int        errors;
  int        beats;
  logic      blocked;
  logic      want_eom;

  // Reference model for one beat of a packet
  function automatic oob_beat_t predict_beat(input oob_cmd_t c, input logic second);
    oob_beat_t b;
    b.valid = 1'b1;
    b.kind  = PE_OP_CMD;
    if (!second)
    begin
      b.cntl      = SOM;
      b.data.opt0 = STOP_CMD;
      b.data.val0 = c.stop_cmd;
      b.data.opt1 = TAG;
      b.data.val1 = c.tag;
    end
    else
    begin
      b.cntl      = EOM;
      b.data.opt0 = SIMD_RELU_CMD;
      b.data.val0 = c.simd_cmd;
      b.data.opt1 = NUM_LANES;
      b.data.val1 = {{(OPT_VAL_W-LANES_W){1'b0}}, c.num_lanes};
    end
    return b;
  endfunction

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      exp_q.delete();
      blocked  = 1'b0;
      want_eom = 1'b0;
    end
    else
    begin
      // --------------------
      // Accepted commands
      if (cmd_valid)
      begin
        // A multi-beat command locks the DUT, nothing behind it comes out
        if (cmd.cntl != SOM_EOM)
          blocked = 1'b1;
        else if (!blocked)
        begin
          exp_q.push_back(predict_beat(cmd, 1'b0));
          exp_q.push_back(predict_beat(cmd, 1'b1));
        end
      end

      // --------------------
      // Downstream beats
      if (want_eom && !oob.valid)
      begin
        $display("At %0t ns the EOM beat did not follow a SOM beat", $time);
        errors++;
      end
      want_eom = oob.valid && (oob.cntl == SOM);
      if (oob.valid)
      begin
        beats++;
        if (exp_q.size() == 0)
        begin
          $display("At %0t ns a beat appeared with no command waiting", $time);
          errors++;
        end
        else
        begin
          exp_beat = exp_q.pop_front();
          if (oob !== exp_beat)
          begin
            $display("[ERROR] %0t ns: oob expected %h got %h", $time, exp_beat, oob);
            errors++;
          end
        end
      end
      if (err && !blocked)
      begin
        $display("At %0t ns err is high but no bad command was sent", $time);
        errors++;
      end
    end
    error_count <= errors;
    pending     <= exp_q.size();
    beat_count  <= beats;
  end

endmodule

`default_nettype wire

// File: src/oob_down_top.sv
/*
 * OOB downstream controller
 * Command queue, prefetch pipe and packet generator between the
 * work-unit decoder and the stack-bus OOB downstream port
 */
`timescale 1ns/1ns
`default_nettype none

module oob_down_top
  import oob_down_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_valid,
  input  oob_cmd_t  cmd,
  output logic      cmd_ready,
  input  logic      oob_ready,
  output oob_beat_t oob,
  output logic      err
);

  // Queue to prefetch
  logic     empty;
  oob_cmd_t head;
  logic     pop;

  // Prefetch to generator
  logic     pipe_valid;
  oob_cmd_t pipe_cmd;
  logic     pipe_read;

  cmd_fifo u_cmd_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .pop       (pop),
    .empty     (empty),
    .head      (head)
  );

  cmd_prefetch u_cmd_prefetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .empty      (empty),
    .head       (head),
    .pop        (pop),
    .pipe_read  (pipe_read),
    .pipe_valid (pipe_valid),
    .pipe_cmd   (pipe_cmd)
  );

  oob_pkt_fsm u_oob_pkt_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .pipe_valid (pipe_valid),
    .pipe_cmd   (pipe_cmd),
    .pipe_read  (pipe_read),
    .oob_ready  (oob_ready),
    .oob        (oob),
    .err        (err)
  );

endmodule

`default_nettype wire

// File: src/oob_pkt_fsm.sv
/*
 * OOB packet generator
 * Turns each prefetched command into a SOM and an EOM beat,
 * registers the beats and latches an error on a multi-beat command
 */
`timescale 1ns/1ns
`default_nettype none

module oob_pkt_fsm
  import oob_down_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      pipe_valid,
  input  oob_cmd_t  pipe_cmd,
  output logic      pipe_read,
  input  logic      oob_ready,
  output oob_beat_t oob,
  output logic      err
);

  fsm_state_e state;
  fsm_state_e state_next;
  logic       oob_ready_q;
  oob_beat_t  beat_d;

  // --------------------
  // Input and state registers

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      oob_ready_q <= 1'b0;
    else
      oob_ready_q <= oob_ready;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= WAIT;
    else
      state <= state_next;
  end

  // --------------------
  // Next state

  always_comb
  begin
    state_next = state;
    case (state)
      WAIT:
      begin
        // Only single-beat commands are supported
        if (pipe_valid && (pipe_cmd.cntl != SOM_EOM))
          state_next = ERR;
        else if (pipe_valid && oob_ready_q)
          state_next = START_PKT;
      end
      START_PKT:
        state_next = SECOND_BEAT;
      SECOND_BEAT:
        state_next = WAIT;
      ERR:
        state_next = ERR;
      default:
        state_next = WAIT;
    endcase
  end

  // Command is released once its second beat is formed
  assign pipe_read = (state == SECOND_BEAT);

  // --------------------
  // Beat formatting

  always_comb
  begin
    beat_d.valid = 1'b0;
    beat_d.cntl  = MOM;
    beat_d.kind  = NA;
    beat_d.data  = OOB_IDLE_WORD;
    case (state)
      START_PKT:
      begin
        beat_d.valid     = 1'b1;
        beat_d.cntl      = SOM;
        beat_d.kind      = PE_OP_CMD;
        beat_d.data.opt0 = STOP_CMD;
        beat_d.data.val0 = pipe_cmd.stop_cmd;
        beat_d.data.opt1 = TAG;
        beat_d.data.val1 = pipe_cmd.tag;
      end
      SECOND_BEAT:
      begin
        beat_d.valid     = 1'b1;
        beat_d.cntl      = EOM;
        beat_d.kind      = PE_OP_CMD;
        beat_d.data.opt0 = SIMD_RELU_CMD;
        beat_d.data.val0 = pipe_cmd.simd_cmd;
        beat_d.data.opt1 = NUM_LANES;
        // Lane count zero-extended into the value field
        beat_d.data.val1 = OPT_VAL_W'(pipe_cmd.num_lanes);
      end
      default:
      begin
        beat_d.valid = 1'b0;
      end
    endcase
  end

  // --------------------
  // Output registers

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      oob <= '0;
    else
      oob <= beat_d;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      err <= 1'b0;
    else
      err <= (state == ERR);
  end

  // Error is sticky until reset
  a_err_sticky : assert property (@(posedge clk) disable iff (!rst_n)
    err |=> err);

endmodule

`default_nettype wire

// File: src/cmd_prefetch.sv
/*
 * Command prefetch pipe
 * Two valid stages behind the queue, the queue output register and a
 * pipe register, kept charged so the head command waits for the generator
 */
`timescale 1ns/1ns
`default_nettype none

module cmd_prefetch
  import oob_down_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     empty,
  input  oob_cmd_t head,
  output logic     pop,
  input  logic     pipe_read,
  output logic     pipe_valid,
  output oob_cmd_t pipe_cmd
);

  // Queue output stage holds head
  logic stage_valid;
  logic stage_adv;

  // Advance the output stage when the pipe stage is free or draining
  assign stage_adv = stage_valid & (~pipe_valid | pipe_read);

  // Refill whenever the output stage is empty or moving on
  assign pop = ~empty & (~stage_valid | stage_adv);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      stage_valid <= 1'b0;
    else if (pop)
      stage_valid <= 1'b1;
    else if (stage_adv)
      stage_valid <= 1'b0;
  end

  // --------------------
  // Pipe stage

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pipe_valid <= 1'b0;
    else if (stage_adv)
      pipe_valid <= 1'b1;
    else if (pipe_read)
      pipe_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (stage_adv)
      pipe_cmd <= head;
  end

  // Generator only consumes a command it has been offered
  a_read_when_valid : assert property (@(posedge clk) disable iff (!rst_n)
    pipe_read |-> pipe_valid);

endmodule

`default_nettype wire

// File: src/cmd_fifo.sv
/*
 * Command queue
 * Registers decoder commands and stores them in a circular buffer,
 * presents the head as registered read data, and drives a registered
 * ready from the almost-full level
 */
`timescale 1ns/1ns
`default_nettype none

module cmd_fifo
  import oob_down_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cmd_valid,
  input  oob_cmd_t cmd,
  output logic     cmd_ready,
  input  logic     pop,
  output logic     empty,
  output oob_cmd_t head
);

  logic               wr_valid_q;
  oob_cmd_t           wr_cmd_q;
  oob_cmd_t           mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_CW-1:0] count;
  logic               almost_full;

  // --------------------
  // Input register stage

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      wr_valid_q <= 1'b0;
    else
      wr_valid_q <= cmd_valid;
  end

  always_ff @(posedge clk)
  begin
    wr_cmd_q <= cmd;
  end

  // --------------------
  // Storage

  always_ff @(posedge clk)
  begin
    if (wr_valid_q)
      mem[wr_ptr] <= wr_cmd_q;
  end

  // Head is registered read data, valid the cycle after pop
  always_ff @(posedge clk)
  begin
    if (pop)
      head <= mem[rd_ptr];
  end

  // --------------------
  // Pointers and occupancy

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_valid_q)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_valid_q, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign empty       = (count == '0);
  assign almost_full = (count >= FIFO_CW'(FIFO_THRESHOLD));

  // Ready lags almost-full by a cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      cmd_ready <= 1'b0;
    else
      cmd_ready <= ~almost_full;
  end

  // --------------------
  // Checks

  // Threshold headroom must cover the ready loop latency
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    wr_valid_q |-> (count != FIFO_CW'(FIFO_DEPTH)));

  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> !empty);

endmodule

`default_nettype wire

// File: src/oob_down_pkg.sv
/*
 * OOB downstream controller package
 * Message control, packet type and option encodings, command and
 * beat layouts, and the sizing of the command queue
 */
`default_nettype none

package oob_down_pkg;

  // --------------------
  // Field widths
  localparam int unsigned TAG_W     = 8;
  localparam int unsigned LANES_W   = 6;
  localparam int unsigned OPT_VAL_W = 8;

  // --------------------
  // Command queue sizing

  // Depth must stay a power of two, pointers wrap naturally
  localparam int unsigned FIFO_DEPTH     = 8;
  // Leaves headroom for commands in flight behind the registered ready
  localparam int unsigned FIFO_THRESHOLD = 5;
  localparam int unsigned FIFO_AW        = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CW        = $clog2(FIFO_DEPTH + 1);

  // --------------------
  // Encodings
  typedef enum logic [1:0] {
    MOM     = 2'd0,
    SOM     = 2'd1,
    EOM     = 2'd2,
    SOM_EOM = 2'd3
  } cntl_e;

  typedef enum logic [1:0] {
    NA        = 2'd0,
    PE_OP_CMD = 2'd1
  } oob_type_e;

  typedef enum logic [3:0] {
    NOP           = 4'd0,
    STOP_CMD      = 4'd1,
    TAG           = 4'd2,
    SIMD_RELU_CMD = 4'd3,
    NUM_LANES     = 4'd4
  } oob_opt_e;

  // Packet generator states
  typedef enum logic [1:0] {
    WAIT        = 2'd0,
    START_PKT   = 2'd1,
    SECOND_BEAT = 2'd2,
    ERR         = 2'd3
  } fsm_state_e;

  // --------------------
  // Structures

  // One instruction command from the work-unit decoder
  typedef struct packed {
    cntl_e                cntl;
    logic [TAG_W-1:0]     tag;
    logic [LANES_W-1:0]   num_lanes;
    logic [OPT_VAL_W-1:0] stop_cmd;
    logic [OPT_VAL_W-1:0] simd_cmd;
  } oob_cmd_t;

  // Data word, same layout in both beats
  typedef struct packed {
    oob_opt_e             opt0;
    logic [OPT_VAL_W-1:0] val0;
    oob_opt_e             opt1;
    logic [OPT_VAL_W-1:0] val1;
  } oob_word_t;

  typedef struct packed {
    logic      valid;
    cntl_e     cntl;
    oob_type_e kind;
    oob_word_t data;
  } oob_beat_t;

  // Word driven between packets
  localparam oob_word_t OOB_IDLE_WORD = '{
    opt0: NOP,
    val0: '0,
    opt1: NOP,
    val1: '0
  };

endpackage

`default_nettype wire
